// ==== src.f ====
rtl/array_cfg_pkg.sv
rtl/ctrl_isa_pkg.sv
rtl/layer_seq_fsm.sv
rtl/glb_read_streamer.sv
rtl/psum_drain_ctrl.sv
rtl/glb_port_ctrl.sv
rtl/cluster_ctrl_top.sv
dv/cluster_ctrl_sva.sv
dv/tb_cluster_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cluster controller testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -f src.f --top-module tb_cluster_ctrl \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_cluster_ctrl > "$LOG" 2>&1 || echo "simulation exited with an error" >> "$LOG"
cat "$LOG"
grep -q "TESTBENCH FAILED" "$LOG" && exit 1
grep -q "TESTBENCH PASSED" "$LOG" || exit 1
exit 0

// ==== dv/tb_cluster_ctrl.sv ====
`timescale 1ns/1ps

module tb_cluster_ctrl
    import array_cfg_pkg::*;
    import ctrl_isa_pkg::*;
;

    localparam logic [31:0] SEED         = 32'h03cc_16c2;
    localparam int          NUM_PASSES   = 5;
    localparam int          PASS_TIMEOUT = 20000;

    logic                  i_clk = 1'b0;
    logic                  i_rst;
    logic                  i_start;
    logic [ITER_W-1:0]     i_layer_e;
    logic [P_W-1:0]        i_layer_p;
    logic [LEN_W-1:0]      i_ifmap_len;
    logic [LEN_W-1:0]      i_wght_len;
    logic [2:0]            o_inst_data;
    logic                  o_inst_valid;
    logic                  i_inst_ready;
    logic [PKT_W-1:0]      o_ifmap_packet;
    logic                  o_ifmap_valid;
    logic [PKT_W-1:0]      o_wght_packet;
    logic                  o_wght_valid;
    logic                  o_psum_out_ready;
    logic                  i_psum_out_valid;
    logic [DATA_W-1:0]     i_psum_out_data;
    logic [DATA_W-1:0]     o_psum_out_data;
    logic [DATA_W-1:0]     i_glb_rd;
    logic                  o_glb_en;
    logic                  o_glb_we;
    logic [GLB_ADDR_W-1:0] o_glb_addr;
    logic [BANK_W-1:0]     o_glb_bank_sel;
    logic                  o_done;

    // glb banks
    logic [DATA_W-1:0] ifmap_mem [GLB_DEPTH];
    logic [DATA_W-1:0] wght_mem [GLB_DEPTH];
    logic [DATA_W-1:0] psum_mem [GLB_DEPTH];

    // reference model state
    opcode_t               exp_ops[$];
    logic [PKT_W-1:0]      exp_ifmap[$];
    logic [PKT_W-1:0]      exp_wght[$];
    logic [GLB_ADDR_W-1:0] exp_wr_addr[$];
    logic [DATA_W-1:0]     exp_wr_data[$];
    logic [DATA_W-1:0]     psum_ref [GLB_DEPTH];
    logic [31:0]           rng_state;
    opcode_t               held_op;
    logic                  hold_pending;
    logic                  done_seen;
    int cur_e;
    int cur_p;
    int cur_ilen;
    int cur_wlen;
    int drain_cnt;
    int ifmap_seen;
    int ifmap_ops;
    int conv_ops;
    int iter_psum;
    int psum_writes;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;

    cluster_ctrl_top i_cluster_ctrl_top (.*);

    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_opcode(input string name, input opcode_t got, input opcode_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_packet(input string name, input logic [PKT_W-1:0] got,
                                input logic [PKT_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [GLB_ADDR_W-1:0] got,
                              input logic [GLB_ADDR_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bank(input string name, input logic [BANK_W-1:0] got,
                              input logic [BANK_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        check_count++;
        error_count++;
        $display("Failure: %s", what);
    endtask

    task automatic check_idle_outputs();
        check_flag("o_inst_valid", o_inst_valid, 1'b0);
        check_flag("o_ifmap_valid", o_ifmap_valid, 1'b0);
        check_flag("o_wght_valid", o_wght_valid, 1'b0);
        check_flag("o_psum_out_ready", o_psum_out_ready, 1'b0);
        check_flag("o_glb_en", o_glb_en, 1'b0);
        check_flag("o_glb_we", o_glb_we, 1'b0);
        check_flag("o_done", o_done, 1'b0);
        check_bank("o_glb_bank_sel", o_glb_bank_sel, BANK_IDLE);
    endtask

    // sample this cycle's outputs, then drive the inputs for the next edge
    task automatic monitor_cycle();
        logic [31:0]           r;
        logic                  ready_next;
        logic                  valid_next;
        logic [DATA_W-1:0]     rd_next;
        logic [GLB_ADDR_W-1:0] wr_addr_next;
        r = next_rand();
        ready_next = (r[1:0] != 2'b00);
        valid_next = r[2];
        if (hold_pending) begin
            check_flag("o_inst_valid", o_inst_valid, 1'b1);
            check_opcode("o_inst_data", opcode_t'(o_inst_data), held_op);
        end
        if (o_inst_valid && ready_next) begin
            if (exp_ops.size() == 0) begin
                report_failure("opcode accepted when none was expected");
            end else begin
                check_opcode("o_inst_data", opcode_t'(o_inst_data), exp_ops.pop_front());
            end
            if (opcode_t'(o_inst_data) == OP_LOAD_IFMAP) begin
                if (ifmap_seen != ifmap_ops * cur_ilen)
                    report_failure("LOAD_IFMAP issued before the previous ifmap stream ended");
                ifmap_ops++;
            end else if (opcode_t'(o_inst_data) == OP_CONV) begin
                if (psum_writes != conv_ops * drain_cnt)
                    report_failure("CONV issued with a wrong number of psum writes so far");
                conv_ops++;
                iter_psum = 0;
            end
        end
        hold_pending = o_inst_valid && !ready_next;
        held_op = opcode_t'(o_inst_data);

        if (o_ifmap_valid) begin
            if (exp_ifmap.size() == 0) begin
                report_failure("ifmap packet arrived when none was expected");
            end else begin
                check_packet("o_ifmap_packet", o_ifmap_packet, exp_ifmap.pop_front());
            end
            ifmap_seen++;
        end
        if (o_wght_valid) begin
            if (exp_wght.size() == 0) begin
                report_failure("weight packet arrived when none was expected");
            end else begin
                check_packet("o_wght_packet", o_wght_packet, exp_wght.pop_front());
            end
        end

        if (o_glb_en && o_glb_we) begin
            check_bank("o_glb_bank_sel", o_glb_bank_sel, BANK_PSUM);
            if (exp_wr_addr.size() == 0) begin
                report_failure("GLB write with no accepted psum pending");
            end else begin
                check_addr("o_glb_addr", o_glb_addr, exp_wr_addr.pop_front());
                check_data("o_psum_out_data", o_psum_out_data, exp_wr_data.pop_front());
            end
            psum_mem[o_glb_addr] = o_psum_out_data;
            psum_writes++;
        end

        // glb read data lines up with the next cycle's packet
        r = next_rand();
        rd_next = r;
        if (o_glb_en && !o_glb_we) begin
            if (o_glb_bank_sel == BANK_IFMAP)
                rd_next = ifmap_mem[o_glb_addr];
            else if (o_glb_bank_sel == BANK_WGHT)
                rd_next = wght_mem[o_glb_addr];
        end

        if (o_done) begin
            done_seen = 1'b1;
            if (psum_writes != cur_e * drain_cnt)
                report_failure("done raised before all psum writes of the pass");
            if (exp_ops.size() != 0)
                report_failure("done raised with opcodes still outstanding");
        end

        r = next_rand();
        if (o_psum_out_ready && valid_next) begin
            wr_addr_next = GLB_ADDR_W'((conv_ops - 1) * drain_cnt + iter_psum);
            exp_wr_addr.push_back(wr_addr_next);
            exp_wr_data.push_back(r);
            psum_ref[wr_addr_next] = r;
            iter_psum++;
        end
        i_inst_ready = ready_next;
        i_psum_out_valid = valid_next;
        i_psum_out_data = r;
        i_glb_rd = rd_next;
    endtask

    task automatic tick();
        @(negedge i_clk);
        monitor_cycle();
    endtask

    task automatic run_pass(input int n);
        logic [31:0] r;
        int          errors_before;
        int          cycles;
        errors_before = error_count;
        r = next_rand();
        cur_e = 2 + int'(r[3:0]) % 3;
        cur_p = 1 + int'(r[5:4]);
        cur_ilen = 1 + int'(r[15:8]) % 40;
        cur_wlen = 1 + int'(r[23:16]) % 40;
        drain_cnt = NUM_PE * cur_p;
        ifmap_seen = 0;
        ifmap_ops = 0;
        conv_ops = 0;
        iter_psum = 0;
        psum_writes = 0;
        done_seen = 1'b0;
        for (int i = 0; i < cur_e; i++) begin
            exp_ops.push_back(OP_LOAD_IFMAP);
            if (i == 0)
                exp_ops.push_back(OP_LOAD_WGHT);
            exp_ops.push_back(OP_CONV);
            for (int t = 0; t < cur_ilen; t++)
                exp_ifmap.push_back({TAG_W'(t), ifmap_mem[GLB_ADDR_W'(i * cur_ilen + t)]});
        end
        for (int t = 0; t < cur_wlen; t++)
            exp_wght.push_back({TAG_W'(t), wght_mem[GLB_ADDR_W'(t)]});

        i_layer_e = ITER_W'(cur_e);
        i_layer_p = P_W'(cur_p);
        i_ifmap_len = LEN_W'(cur_ilen);
        i_wght_len = LEN_W'(cur_wlen);
        i_start = 1'b1;
        tick();
        i_start = 1'b0;
        check_flag("o_inst_valid", o_inst_valid, 1'b1);

        cycles = 0;
        while (!done_seen && cycles < PASS_TIMEOUT) begin
            tick();
            cycles++;
        end
        if (!done_seen) begin
            $display("Failure: test %0d saw no done within %0d cycles", n, PASS_TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end
        tick();
        check_flag("o_done", o_done, 1'b0);
        if (exp_ifmap.size() != 0 || exp_wght.size() != 0)
            report_failure("pass ended with packets still missing");
        if (exp_wr_addr.size() != 0)
            report_failure("pass ended with accepted psums never written");
        // bank 3 holds every accepted psum of the pass at its slot
        for (int a = 0; a < cur_e * drain_cnt; a++)
            check_data("psum_mem", psum_mem[GLB_ADDR_W'(a)], psum_ref[GLB_ADDR_W'(a)]);
        $display("test %0d e=%0d p=%0d ifmap_len=%0d wght_len=%0d: %0d errors",
                 n, cur_e, cur_p, cur_ilen, cur_wlen, error_count - errors_before);
        test_count++;
    endtask

    initial begin
        rng_state = SEED;
        i_rst = 1'b1;
        i_start = 1'b0;
        i_layer_e = '0;
        i_layer_p = '0;
        i_ifmap_len = '0;
        i_wght_len = '0;
        i_inst_ready = 1'b0;
        i_psum_out_valid = 1'b0;
        i_psum_out_data = '0;
        i_glb_rd = '0;
        hold_pending = 1'b0;
        for (int a = 0; a < GLB_DEPTH; a++) begin
            ifmap_mem[GLB_ADDR_W'(a)] = next_rand();
            wght_mem[GLB_ADDR_W'(a)] = next_rand();
            psum_mem[GLB_ADDR_W'(a)] = '0;
            psum_ref[GLB_ADDR_W'(a)] = '0;
        end

        repeat (3) begin
            @(negedge i_clk);
            check_idle_outputs();
        end
        i_rst = 1'b0;
        @(negedge i_clk);
        check_idle_outputs();
        $display("test 0 reset: %0d errors", error_count);
        test_count = 1;

        for (int n = 1; n <= NUM_PASSES; n++)
            run_pass(n);

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/cluster_ctrl_sva.sv ====
`timescale 1ns/1ps

module cluster_ctrl_sva
    import array_cfg_pkg::*;
(
    input logic              i_clk,
    input logic              i_rst,
    input logic [2:0]        o_inst_data,
    input logic              o_inst_valid,
    input logic              i_inst_ready,
    input logic              o_glb_en,
    input logic              o_glb_we,
    input logic [BANK_W-1:0] o_glb_bank_sel,
    input logic              o_done
);

    // stalled opcode stays put
    a_inst_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_inst_valid && !i_inst_ready |=> o_inst_valid && $stable(o_inst_data))
        else $error("instruction dropped or changed while stalled");

    // only the psum drain writes
    a_write_bank: assert property (@(posedge i_clk) disable iff (i_rst)
        o_glb_we |-> o_glb_en && o_glb_bank_sel == BANK_PSUM)
        else $error("GLB write outside the psum bank");

    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_done |=> !o_done)
        else $error("done held longer than one cycle");

endmodule

bind cluster_ctrl_top cluster_ctrl_sva u_ctrl_sva (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .o_inst_data    (o_inst_data),
    .o_inst_valid   (o_inst_valid),
    .i_inst_ready   (i_inst_ready),
    .o_glb_en       (o_glb_en),
    .o_glb_we       (o_glb_we),
    .o_glb_bank_sel (o_glb_bank_sel),
    .o_done         (o_done)
);

// ==== rtl/cluster_ctrl_top.sv ====
`timescale 1ns/1ps

module cluster_ctrl_top
    import array_cfg_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic [ITER_W-1:0]     i_layer_e,
    input  logic [P_W-1:0]        i_layer_p,
    input  logic [LEN_W-1:0]      i_ifmap_len,
    input  logic [LEN_W-1:0]      i_wght_len,
    output logic [2:0]            o_inst_data,
    output logic                  o_inst_valid,
    input  logic                  i_inst_ready,
    output logic [PKT_W-1:0]      o_ifmap_packet,
    output logic                  o_ifmap_valid,
    output logic [PKT_W-1:0]      o_wght_packet,
    output logic                  o_wght_valid,
    output logic                  o_psum_out_ready,
    input  logic                  i_psum_out_valid,
    input  logic [DATA_W-1:0]     i_psum_out_data,
    output logic [DATA_W-1:0]     o_psum_out_data,
    input  logic [DATA_W-1:0]     i_glb_rd,
    output logic                  o_glb_en,
    output logic                  o_glb_we,
    output logic [GLB_ADDR_W-1:0] o_glb_addr,
    output logic [BANK_W-1:0]     o_glb_bank_sel,
    output logic                  o_done
);

    logic                  ifmap_start;
    logic [GLB_ADDR_W-1:0] ifmap_base;
    logic [LEN_W-1:0]      ifmap_len;
    logic                  wght_start;
    logic [LEN_W-1:0]      wght_len;
    logic                  drain_start;
    logic [GLB_ADDR_W-1:0] drain_base;
    logic [LEN_W-1:0]      drain_count;

    logic                  ifmap_rd_en;
    logic [GLB_ADDR_W-1:0] ifmap_addr;
    logic                  ifmap_pkt_valid;
    logic [TAG_W-1:0]      ifmap_tag;
    logic                  ifmap_done;

    logic                  wght_rd_en;
    logic [GLB_ADDR_W-1:0] wght_addr;
    logic                  wght_pkt_valid;
    logic [TAG_W-1:0]      wght_tag;
    logic                  wght_done;

    logic                  psum_wr_en;
    logic [GLB_ADDR_W-1:0] psum_addr;
    logic                  drain_done;

    layer_seq_fsm u_seq_fsm (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_layer_e     (i_layer_e),
        .i_layer_p     (i_layer_p),
        .i_ifmap_len   (i_ifmap_len),
        .i_wght_len    (i_wght_len),
        .i_inst_ready  (i_inst_ready),
        .i_ifmap_done  (ifmap_done),
        .i_wght_done   (wght_done),
        .i_drain_done  (drain_done),
        .o_inst_data   (o_inst_data),
        .o_inst_valid  (o_inst_valid),
        .o_ifmap_start (ifmap_start),
        .o_ifmap_base  (ifmap_base),
        .o_ifmap_len   (ifmap_len),
        .o_wght_start  (wght_start),
        .o_wght_len    (wght_len),
        .o_drain_start (drain_start),
        .o_drain_base  (drain_base),
        .o_drain_count (drain_count),
        .o_done        (o_done)
    );

    glb_read_streamer u_ifmap_stream (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (ifmap_start),
        .i_base      (ifmap_base),
        .i_len       (ifmap_len),
        .o_rd_en     (ifmap_rd_en),
        .o_rd_addr   (ifmap_addr),
        .o_pkt_valid (ifmap_pkt_valid),
        .o_tag       (ifmap_tag),
        .o_done      (ifmap_done)
    );

    // weights always start at bank address 0
    glb_read_streamer u_wght_stream (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (wght_start),
        .i_base      ('0),
        .i_len       (wght_len),
        .o_rd_en     (wght_rd_en),
        .o_rd_addr   (wght_addr),
        .o_pkt_valid (wght_pkt_valid),
        .o_tag       (wght_tag),
        .o_done      (wght_done)
    );

    psum_drain_ctrl u_psum_drain (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_start          (drain_start),
        .i_base           (drain_base),
        .i_count          (drain_count),
        .i_psum_out_valid (i_psum_out_valid),
        .i_psum_out_data  (i_psum_out_data),
        .o_psum_out_ready (o_psum_out_ready),
        .o_wr_en          (psum_wr_en),
        .o_wr_addr        (psum_addr),
        .o_wr_data        (o_psum_out_data),
        .o_done           (drain_done)
    );

    glb_port_ctrl u_glb_port (
        .i_ifmap_rd_en     (ifmap_rd_en),
        .i_ifmap_addr      (ifmap_addr),
        .i_ifmap_pkt_valid (ifmap_pkt_valid),
        .i_ifmap_tag       (ifmap_tag),
        .i_wght_rd_en      (wght_rd_en),
        .i_wght_addr       (wght_addr),
        .i_wght_pkt_valid  (wght_pkt_valid),
        .i_wght_tag        (wght_tag),
        .i_psum_wr_en      (psum_wr_en),
        .i_psum_addr       (psum_addr),
        .i_glb_rd          (i_glb_rd),
        .o_glb_en          (o_glb_en),
        .o_glb_we          (o_glb_we),
        .o_glb_addr        (o_glb_addr),
        .o_glb_bank_sel    (o_glb_bank_sel),
        .o_ifmap_packet    (o_ifmap_packet),
        .o_ifmap_valid     (o_ifmap_valid),
        .o_wght_packet     (o_wght_packet),
        .o_wght_valid      (o_wght_valid)
    );

endmodule

// ==== rtl/glb_port_ctrl.sv ====
`timescale 1ns/1ps

module glb_port_ctrl
    import array_cfg_pkg::*;
(
    input  logic                  i_ifmap_rd_en,
    input  logic [GLB_ADDR_W-1:0] i_ifmap_addr,
    input  logic                  i_ifmap_pkt_valid,
    input  logic [TAG_W-1:0]      i_ifmap_tag,
    input  logic                  i_wght_rd_en,
    input  logic [GLB_ADDR_W-1:0] i_wght_addr,
    input  logic                  i_wght_pkt_valid,
    input  logic [TAG_W-1:0]      i_wght_tag,
    input  logic                  i_psum_wr_en,
    input  logic [GLB_ADDR_W-1:0] i_psum_addr,
    input  logic [DATA_W-1:0]     i_glb_rd,
    output logic                  o_glb_en,
    output logic                  o_glb_we,
    output logic [GLB_ADDR_W-1:0] o_glb_addr,
    output logic [BANK_W-1:0]     o_glb_bank_sel,
    output logic [PKT_W-1:0]      o_ifmap_packet,
    output logic                  o_ifmap_valid,
    output logic [PKT_W-1:0]      o_wght_packet,
    output logic                  o_wght_valid
);

    // the sequencer never runs two clients at once
    always_comb begin
        o_glb_en       = 1'b0;
        o_glb_we       = 1'b0;
        o_glb_addr     = '0;
        o_glb_bank_sel = BANK_IDLE;
        if (i_psum_wr_en) begin
            o_glb_en       = 1'b1;
            o_glb_we       = 1'b1;
            o_glb_addr     = i_psum_addr;
            o_glb_bank_sel = BANK_PSUM;
        end else if (i_ifmap_rd_en) begin
            o_glb_en       = 1'b1;
            o_glb_addr     = i_ifmap_addr;
            o_glb_bank_sel = BANK_IFMAP;
        end else if (i_wght_rd_en) begin
            o_glb_en       = 1'b1;
            o_glb_addr     = i_wght_addr;
            o_glb_bank_sel = BANK_WGHT;
        end
    end

    // tag above data, zero between packets
    assign o_ifmap_packet = i_ifmap_pkt_valid ? {i_ifmap_tag, i_glb_rd} : '0;
    assign o_ifmap_valid  = i_ifmap_pkt_valid;
    assign o_wght_packet  = i_wght_pkt_valid ? {i_wght_tag, i_glb_rd} : '0;
    assign o_wght_valid   = i_wght_pkt_valid;

endmodule

// ==== rtl/psum_drain_ctrl.sv ====
`timescale 1ns/1ps

module psum_drain_ctrl
    import array_cfg_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic [GLB_ADDR_W-1:0] i_base,
    input  logic [LEN_W-1:0]      i_count,
    input  logic                  i_psum_out_valid,
    input  logic [DATA_W-1:0]     i_psum_out_data,
    output logic                  o_psum_out_ready,
    output logic                  o_wr_en,
    output logic [GLB_ADDR_W-1:0] o_wr_addr,
    output logic [DATA_W-1:0]     o_wr_data,
    output logic                  o_done
);

    logic [LEN_W-1:0]      acc_cnt;
    logic [GLB_ADDR_W-1:0] next_addr;
    logic                  accept;
    logic                  last_word;

    assign accept    = o_psum_out_ready && i_psum_out_valid;
    assign last_word = (acc_cnt == i_count - LEN_W'(1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_psum_out_ready <= 1'b0;
            o_wr_en          <= 1'b0;
            o_done           <= 1'b0;
            acc_cnt          <= '0;
        end else begin
            o_wr_en <= accept;
            // done rides with the final write
            o_done  <= accept && last_word;
            if (i_start) begin
                o_psum_out_ready <= 1'b1;
                acc_cnt          <= '0;
            end else if (accept) begin
                acc_cnt <= acc_cnt + LEN_W'(1);
                if (last_word) begin
                    o_psum_out_ready <= 1'b0;
                end
            end
        end
    end

    // write address and data registered with each accepted word
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            next_addr <= i_base;
        end else if (accept) begin
            next_addr <= next_addr + GLB_ADDR_W'(1);
        end
        if (accept) begin
            o_wr_addr <= next_addr;
            o_wr_data <= i_psum_out_data;
        end
    end

endmodule

// ==== rtl/glb_read_streamer.sv ====
`timescale 1ns/1ps

module glb_read_streamer
    import array_cfg_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic [GLB_ADDR_W-1:0] i_base,
    input  logic [LEN_W-1:0]      i_len,
    output logic                  o_rd_en,
    output logic [GLB_ADDR_W-1:0] o_rd_addr,
    output logic                  o_pkt_valid,
    output logic [TAG_W-1:0]      o_tag,
    output logic                  o_done
);

    logic [LEN_W-1:0] word_cnt;
    logic             last_word;

    assign last_word = (word_cnt == i_len - LEN_W'(1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rd_en     <= 1'b0;
            o_pkt_valid <= 1'b0;
            o_done      <= 1'b0;
            word_cnt    <= '0;
        end else begin
            // read data shows up one cycle after the address
            o_pkt_valid <= o_rd_en;
            o_done      <= o_rd_en && last_word;
            if (i_start) begin
                o_rd_en  <= 1'b1;
                word_cnt <= '0;
            end else if (o_rd_en) begin
                if (last_word) begin
                    o_rd_en <= 1'b0;
                end else begin
                    word_cnt <= word_cnt + LEN_W'(1);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            o_rd_addr <= i_base;
        end else if (o_rd_en) begin
            o_rd_addr <= o_rd_addr + GLB_ADDR_W'(1);
        end
        o_tag <= TAG_W'(word_cnt);
    end

endmodule

// ==== rtl/layer_seq_fsm.sv ====
`timescale 1ns/1ps

module layer_seq_fsm
    import array_cfg_pkg::*;
    import ctrl_isa_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic [ITER_W-1:0]     i_layer_e,
    input  logic [P_W-1:0]        i_layer_p,
    input  logic [LEN_W-1:0]      i_ifmap_len,
    input  logic [LEN_W-1:0]      i_wght_len,
    input  logic                  i_inst_ready,
    input  logic                  i_ifmap_done,
    input  logic                  i_wght_done,
    input  logic                  i_drain_done,
    output opcode_t               o_inst_data,
    output logic                  o_inst_valid,
    output logic                  o_ifmap_start,
    output logic [GLB_ADDR_W-1:0] o_ifmap_base,
    output logic [LEN_W-1:0]      o_ifmap_len,
    output logic                  o_wght_start,
    output logic [LEN_W-1:0]      o_wght_len,
    output logic                  o_drain_start,
    output logic [GLB_ADDR_W-1:0] o_drain_base,
    output logic [LEN_W-1:0]      o_drain_count,
    output logic                  o_done
);

    seq_state_t        state;
    logic [ITER_W-1:0] layer_e_q;
    logic [P_W-1:0]    layer_p_q;
    logic [LEN_W-1:0]  ifmap_len_q;
    logic [LEN_W-1:0]  wght_len_q;
    logic [ITER_W-1:0] iter_q;
    logic              inst_fire;
    logic              last_iter;

    assign inst_fire = o_inst_valid && i_inst_ready;
    assign last_iter = (iter_q == layer_e_q - ITER_W'(1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state         <= IDLE;
            o_inst_data   <= OP_LOAD_IFMAP;
            o_inst_valid  <= 1'b0;
            o_ifmap_start <= 1'b0;
            o_wght_start  <= 1'b0;
            o_drain_start <= 1'b0;
            iter_q        <= '0;
        end else begin
            // start strobes last one cycle
            o_ifmap_start <= 1'b0;
            o_wght_start  <= 1'b0;
            o_drain_start <= 1'b0;

            case (state)
                IDLE: begin
                    if (i_start) begin
                        iter_q       <= '0;
                        o_inst_data  <= OP_LOAD_IFMAP;
                        o_inst_valid <= 1'b1;
                        state        <= IFMAP_INST;
                    end
                end
                IFMAP_INST: begin
                    if (inst_fire) begin
                        o_inst_valid  <= 1'b0;
                        o_ifmap_start <= 1'b1;
                        state         <= IFMAP_LOAD;
                    end
                end
                IFMAP_LOAD: begin
                    if (i_ifmap_done) begin
                        o_inst_valid <= 1'b1;
                        // weights stay resident after the first iteration
                        if (iter_q == '0) begin
                            o_inst_data <= OP_LOAD_WGHT;
                            state       <= WGHT_INST;
                        end else begin
                            o_inst_data <= OP_CONV;
                            state       <= CONV_INST;
                        end
                    end
                end
                WGHT_INST: begin
                    if (inst_fire) begin
                        o_inst_valid <= 1'b0;
                        o_wght_start <= 1'b1;
                        state        <= WGHT_LOAD;
                    end
                end
                WGHT_LOAD: begin
                    if (i_wght_done) begin
                        o_inst_data  <= OP_CONV;
                        o_inst_valid <= 1'b1;
                        state        <= CONV_INST;
                    end
                end
                CONV_INST: begin
                    if (inst_fire) begin
                        o_inst_valid  <= 1'b0;
                        o_drain_start <= 1'b1;
                        state         <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (i_drain_done) begin
                        if (last_iter) begin
                            state <= DONE;
                        end else begin
                            iter_q       <= iter_q + ITER_W'(1);
                            o_inst_data  <= OP_LOAD_IFMAP;
                            o_inst_valid <= 1'b1;
                            state        <= IFMAP_INST;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // layer fields, held for the whole pass
    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_start) begin
            layer_e_q   <= i_layer_e;
            layer_p_q   <= i_layer_p;
            ifmap_len_q <= i_ifmap_len;
            wght_len_q  <= i_wght_len;
        end
    end

    assign o_ifmap_len   = ifmap_len_q;
    assign o_wght_len    = wght_len_q;
    assign o_ifmap_base  = GLB_ADDR_W'(iter_q) * GLB_ADDR_W'(ifmap_len_q);
    // one psum per pe per output column
    assign o_drain_count = LEN_W'(NUM_PE) * LEN_W'(layer_p_q);
    assign o_drain_base  = GLB_ADDR_W'(iter_q) * GLB_ADDR_W'(o_drain_count);
    assign o_done        = (state == DONE);

endmodule

// ==== rtl/ctrl_isa_pkg.sv ====
package ctrl_isa_pkg;

    // opcodes understood by the pe array
    typedef enum logic [2:0] {
        OP_LOAD_IFMAP = 3'd1,
        OP_LOAD_WGHT  = 3'd2,
        OP_CONV       = 3'd3
    } opcode_t;

    // layer sequencer states
    // *_INST holds an opcode on the channel until accepted
    // *_LOAD and DRAIN wait for the matching done strobe
    typedef enum logic [2:0] {
        IDLE,
        IFMAP_INST,
        IFMAP_LOAD,
        WGHT_INST,
        WGHT_LOAD,
        CONV_INST,
        DRAIN,
        DONE
    } seq_state_t;

endpackage

// ==== rtl/array_cfg_pkg.sv ====
package array_cfg_pkg;

    // pe array shape
    localparam int NUM_ROWS = 3;
    localparam int NUM_COLS = 3;
    localparam int NUM_PE   = NUM_ROWS * NUM_COLS;

    // data path
    localparam int DATA_W = 32;

    // global buffer, one bank per data type
    localparam int GLB_DEPTH  = 512;
    localparam int GLB_ADDR_W = $clog2(GLB_DEPTH);

    // packets carry the word index above the data
    localparam int TAG_W = 8;
    localparam int PKT_W = TAG_W + DATA_W;

    // bank select codes
    localparam int          BANK_W     = 2;
    localparam logic [1:0]  BANK_IDLE  = 2'd0;
    localparam logic [1:0]  BANK_IFMAP = 2'd1;
    localparam logic [1:0]  BANK_WGHT  = 2'd2;
    localparam logic [1:0]  BANK_PSUM  = 2'd3;

    // layer field widths
    localparam int LEN_W  = 8;
    localparam int ITER_W = 5;
    localparam int P_W    = 5;

endpackage
